// ==== rtl/rvv_retire_pkg.sv ====
//////////////////////////////////////////////////
// widths, encodings and bus structs of the vector
// retire path; every rtl block and the testbench
// import this package with a wildcard import
//////////////////////////////////////////////////
`default_nettype none

package rvv_retire_pkg;

  //////////////////////////////////////////////////
  // sizes
  localparam int num_rt_uop = 4;  // uops offered per cycle
  localparam int rob_depth  = 8;
  localparam int vlen       = 64;
  localparam int vlenb      = vlen / 8;
  localparam int xlen       = 32;
  localparam int reg_idx_w  = 5;

  localparam int num_vreg  = 2 ** reg_idx_w;          // 32 vector registers
  localparam int rob_ptr_w = $clog2(rob_depth);
  localparam int rob_cnt_w = $clog2(rob_depth + 1);   // 0..rob_depth
  localparam int rt_cnt_w  = $clog2(num_rt_uop + 1);  // 0..num_rt_uop pops

  //////////////////////////////////////////////////
  // per-byte class of the destination register
  typedef logic [1:0] byte_type_t;

  localparam byte_type_t bt_tail          = 2'b00;
  localparam byte_type_t bt_body_inactive = 2'b01;  // masked off
  localparam byte_type_t bt_body_active   = 2'b11;  // only class that writes

  // one result word, vector view or scalar view
  typedef union packed {
    logic [vlen-1:0] vec;
    struct packed {
      logic [vlen-xlen-1:0] pad;
      logic [xlen-1:0]      data;  // scalar result sits in the low bits
    } scl;
  } rt_data_u;

  typedef struct packed {
    logic [7:0] vl;
    logic [7:0] vstart;
    logic [7:0] vtype;
  } vcsr_t;

  //////////////////////////////////////////////////
  // bus structs
  typedef struct packed {
    logic                         w_valid;    // uop writes a register
    logic                         w_type;     // 0 vrf, 1 xrf
    logic [reg_idx_w-1:0]         w_index;
    byte_type_t [vlenb-1:0]       vd_type;
    rt_data_u                     w_data;
    logic                         trap_flag;
    vcsr_t                        vector_csr; // state restored on trap
    logic                         vxsat;
  } rob2rt_t;

  typedef struct packed {
    logic [reg_idx_w-1:0] rt_index;
    logic [vlen-1:0]      rt_data;
    logic [vlenb-1:0]     rt_strobe;  // one bit per byte
  } rt2vrf_t;

  typedef struct packed {
    logic [reg_idx_w-1:0] rt_index;
    logic [xlen-1:0]      rt_data;
  } rt2xrf_t;

endpackage

`default_nettype wire

// ==== rtl/rvv_retire_rob.sv ====
//////////////////////////////////////////////////
// reorder buffer of completed uops
// offers its four oldest entries to the retire
// stage and pops the accepted in-order prefix;
// a popped trap flushes every younger entry
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module rvv_retire_rob import rvv_retire_pkg::*; (
  input  logic                            clk,
  input  logic                            arst_n,
  // enqueue side
  input  logic                            enq_valid,
  input  rob2rt_t                         enq_uop,
  output logic                            enq_ready,
  // retire side with entry 0 oldest
  output logic    [num_rt_uop-1:0]        rob2rt_write_valid,
  output rob2rt_t [num_rt_uop-1:0]        rob2rt_write_data,
  input  logic    [num_rt_uop-1:0]        rob2rt_write_ready
);

  rob2rt_t              mem [rob_depth];  // payload
  logic [rob_ptr_w-1:0] head_q;
  logic [rob_ptr_w-1:0] tail_q;
  logic [rob_cnt_w-1:0] cnt_q;
  logic                 enq_fire;
  logic [rt_cnt_w-1:0]  pop_cnt;
  logic                 flush;
  logic                 stop;

  assign enq_ready = (cnt_q != rob_cnt_w'(rob_depth));
  assign enq_fire  = enq_valid && enq_ready;

  // four oldest entries wrap through the pointer width
  for (genvar i = 0; i < num_rt_uop; i++) begin : g_head
    assign rob2rt_write_valid[i] = (cnt_q > rob_cnt_w'(i));
    assign rob2rt_write_data[i]  = mem[head_q + rob_ptr_w'(i)];
  end

  //////////////////////////////////////////////////
  // pop count is the ready prefix cut after a trap
  always_comb begin
    pop_cnt = '0;
    flush   = 1'b0;
    stop    = 1'b0;
    for (int i = 0; i < num_rt_uop; i++) begin
      if (!stop && rob2rt_write_valid[i] && rob2rt_write_ready[i]) begin
        pop_cnt = pop_cnt + rt_cnt_w'(1);
        if (rob2rt_write_data[i].trap_flag) begin
          flush = 1'b1;  // younger ones go too
          stop  = 1'b1;
        end
      end else begin
        stop = 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      head_q <= '0;
      tail_q <= '0;
      cnt_q  <= '0;
    end else if (flush) begin
      // drop stored entries but keep an enqueue on this edge
      head_q <= tail_q;
      tail_q <= tail_q + rob_ptr_w'(enq_fire);
      cnt_q  <= rob_cnt_w'(enq_fire);
    end else begin
      head_q <= head_q + rob_ptr_w'(pop_cnt);
      tail_q <= tail_q + rob_ptr_w'(enq_fire);
      cnt_q  <= cnt_q + rob_cnt_w'(enq_fire) - rob_cnt_w'(pop_cnt);
    end
  end

  always_ff @(posedge clk) begin
    if (enq_fire) begin
      mem[tail_q] <= enq_uop;
    end
  end

  //////////////////////////////////////////////////
  // checks
  a_cnt_bound: assert property (@(posedge clk) disable iff (!arst_n)
    cnt_q <= rob_cnt_w'(rob_depth))
    else $error("rob occupancy above depth");

  // an enqueue into a full buffer would move tail past head
  a_ptr_cnt: assert property (@(posedge clk) disable iff (!arst_n)
    rob_ptr_w'(tail_q - head_q) == rob_ptr_w'(cnt_q))
    else $error("rob pointers disagree with occupancy");

endmodule

`default_nettype wire

// ==== rtl/rvv_backend_retire.sv ====
//////////////////////////////////////////////////
// combinational retire stage
// sorts up to four uops into vrf and xrf writes,
// resolves waw overlaps into disjoint byte strobes,
// drops uops younger than a trap and forwards the
// trap's config state and the saturation flag
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module rvv_backend_retire import rvv_retire_pkg::*; (
  // from rob, entry 0 oldest
  input  logic    [num_rt_uop-1:0]  rob2rt_write_valid,
  input  rob2rt_t [num_rt_uop-1:0]  rob2rt_write_data,
  output logic    [num_rt_uop-1:0]  rob2rt_write_ready,
  // scalar register file
  output logic    [num_rt_uop-1:0]  rt2xrf_write_valid,
  output rt2xrf_t [num_rt_uop-1:0]  rt2xrf_write_data,
  input  logic    [num_rt_uop-1:0]  rt2xrf_write_ready,
  // vector register file, no ready
  output logic    [num_rt_uop-1:0]  rt2vrf_write_valid,
  output rt2vrf_t [num_rt_uop-1:0]  rt2vrf_write_data,
  // config state and saturation
  output logic                      rt2vcsr_write_valid,
  output vcsr_t                     rt2vcsr_write_data,
  output logic                      rt2vsat_write_valid,
  output logic                      rt2vsat_write_data
);

  logic [num_rt_uop-1:0]             is_xrf;
  logic [num_rt_uop-1:0]             is_vrf;
  logic [num_rt_uop-1:0]             older_ok;  // every older entry leaves this cycle
  logic [num_rt_uop-1:0]             go;
  logic [num_rt_uop-1:0]             retire;
  logic [num_rt_uop-1:0]             vxsat_in;
  logic [num_rt_uop-1:0][vlenb-1:0]  byte_en;
  logic [num_rt_uop-1:0][vlenb-1:0]  strobe;

  //////////////////////////////////////////////////
  // decode
  always_comb begin
    for (int i = 0; i < num_rt_uop; i++) begin
      is_xrf[i]   = rob2rt_write_data[i].w_valid && rob2rt_write_data[i].w_type;
      is_vrf[i]   = rob2rt_write_data[i].w_valid && !rob2rt_write_data[i].w_type;
      vxsat_in[i] = rob2rt_write_data[i].vxsat;
      for (int b = 0; b < vlenb; b++) begin
        byte_en[i][b] = (rob2rt_write_data[i].vd_type[b] == bt_body_active);
      end
    end
  end

  // xrf uops wait for their port, the rest never stall
  always_comb begin
    for (int i = 0; i < num_rt_uop; i++) begin
      rob2rt_write_ready[i] = is_xrf[i] ? rt2xrf_write_ready[i] : 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // ordering and trap mask
  always_comb begin
    older_ok[0] = 1'b1;
    for (int i = 1; i < num_rt_uop; i++) begin
      older_ok[i] = older_ok[i-1] && rob2rt_write_valid[i-1] && rob2rt_write_ready[i-1]
                    && !rob2rt_write_data[i-1].trap_flag;
    end
  end

  assign go     = rob2rt_write_valid & older_ok;
  assign retire = go & rob2rt_write_ready;  // entries popped this cycle

  assign rt2xrf_write_valid = go & is_xrf;  // held while port not ready
  assign rt2vrf_write_valid = go & is_vrf;

  //////////////////////////////////////////////////
  // waw: a younger write to the same register wins its bytes
  always_comb begin
    for (int i = 0; i < num_rt_uop; i++) begin
      strobe[i] = byte_en[i];
      for (int j = i + 1; j < num_rt_uop; j++) begin
        if (rt2vrf_write_valid[j] &&
            rob2rt_write_data[j].w_index == rob2rt_write_data[i].w_index) begin
          strobe[i] = strobe[i] & ~byte_en[j];
        end
      end
    end
  end

  // pack port data
  always_comb begin
    for (int i = 0; i < num_rt_uop; i++) begin
      rt2vrf_write_data[i].rt_index  = rob2rt_write_data[i].w_index;
      rt2vrf_write_data[i].rt_data   = rob2rt_write_data[i].w_data.vec;
      rt2vrf_write_data[i].rt_strobe = strobe[i];
      rt2xrf_write_data[i].rt_index  = rob2rt_write_data[i].w_index;
      rt2xrf_write_data[i].rt_data   = rob2rt_write_data[i].w_data.scl.data;  // low xlen
    end
  end

  //////////////////////////////////////////////////
  // vcsr from the oldest retiring trap
  always_comb begin
    rt2vcsr_write_valid = 1'b0;
    rt2vcsr_write_data  = '0;
    for (int i = num_rt_uop - 1; i >= 0; i--) begin
      if (retire[i] && rob2rt_write_data[i].trap_flag) begin
        rt2vcsr_write_valid = 1'b1;
        rt2vcsr_write_data  = rob2rt_write_data[i].vector_csr;
      end
    end
  end

  assign rt2vsat_write_valid = |retire;
  assign rt2vsat_write_data  = |(retire & vxsat_in);  // discarded uops never count

endmodule

`default_nettype wire

// ==== rtl/rvv_vrf.sv ====
//////////////////////////////////////////////////
// vector register file, 32 x vlen
// four byte-strobed write ports applied in age
// order at the clock edge; one combinational read
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module rvv_vrf import rvv_retire_pkg::*; (
  input  logic                            clk,
  input  logic                            arst_n,
  input  logic    [num_rt_uop-1:0]        rt2vrf_write_valid,
  input  rt2vrf_t [num_rt_uop-1:0]        rt2vrf_write_data,
  input  logic    [reg_idx_w-1:0]         rd_index,
  output logic    [vlen-1:0]              rd_data
);

  logic [vlen-1:0] regs [num_vreg];
  logic            waw_overlap;

  // port 3 is youngest, so it lands last
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int r = 0; r < num_vreg; r++) begin
        regs[r] <= '0;
      end
    end else begin
      for (int p = 0; p < num_rt_uop; p++) begin
        if (rt2vrf_write_valid[p]) begin
          for (int b = 0; b < vlenb; b++) begin
            if (rt2vrf_write_data[p].rt_strobe[b]) begin
              regs[rt2vrf_write_data[p].rt_index][b*8 +: 8] <=
                rt2vrf_write_data[p].rt_data[b*8 +: 8];
            end
          end
        end
      end
    end
  end

  assign rd_data = regs[rd_index];

  //////////////////////////////////////////////////
  // retire must hand over disjoint strobes per register
  always_comb begin
    waw_overlap = 1'b0;
    for (int i = 0; i < num_rt_uop; i++) begin
      for (int j = i + 1; j < num_rt_uop; j++) begin
        if (rt2vrf_write_valid[i] && rt2vrf_write_valid[j] &&
            rt2vrf_write_data[i].rt_index == rt2vrf_write_data[j].rt_index &&
            |(rt2vrf_write_data[i].rt_strobe & rt2vrf_write_data[j].rt_strobe)) begin
          waw_overlap = 1'b1;
        end
      end
    end
  end

  a_waw_disjoint: assert property (@(posedge clk) disable iff (!arst_n) !waw_overlap)
    else $error("overlapping vrf strobes on one register");

endmodule

`default_nettype wire

// ==== rtl/rvv_vcsr.sv ====
//////////////////////////////////////////////////
// vector config state and sticky vxsat
// state loads on a trap write; vxsat only clears
// on reset
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module rvv_vcsr import rvv_retire_pkg::*; (
  input  logic   clk,
  input  logic   arst_n,
  input  logic   rt2vcsr_write_valid,
  input  vcsr_t  rt2vcsr_write_data,
  input  logic   rt2vsat_write_valid,
  input  logic   rt2vsat_write_data,
  output vcsr_t  vcsr_q,
  output logic   vxsat_q
);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      vcsr_q <= '0;
    end else if (rt2vcsr_write_valid) begin
      vcsr_q <= rt2vcsr_write_data;  // trap restores vl/vstart/vtype
    end
  end

  // sticky, a zero write never clears it
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      vxsat_q <= 1'b0;
    end else if (rt2vsat_write_valid) begin
      vxsat_q <= vxsat_q | rt2vsat_write_data;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/rvv_retire_top.sv ====
//////////////////////////////////////////////////
// retire path top: rob, retire stage, vrf, vcsr
// xrf write ports leave here with their own ready
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module rvv_retire_top import rvv_retire_pkg::*; (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      enq_valid,
  input  rob2rt_t                   enq_uop,
  output logic                      enq_ready,
  output logic    [num_rt_uop-1:0]  rt2xrf_write_valid,
  output rt2xrf_t [num_rt_uop-1:0]  rt2xrf_write_data,
  input  logic    [num_rt_uop-1:0]  rt2xrf_write_ready,
  input  logic    [reg_idx_w-1:0]   rd_index,
  output logic    [vlen-1:0]        rd_data,
  output vcsr_t                     vcsr_q,
  output logic                      vxsat_q
);

  logic    [num_rt_uop-1:0]  rob2rt_write_valid;
  rob2rt_t [num_rt_uop-1:0]  rob2rt_write_data;
  logic    [num_rt_uop-1:0]  rob2rt_write_ready;
  logic    [num_rt_uop-1:0]  rt2vrf_write_valid;
  rt2vrf_t [num_rt_uop-1:0]  rt2vrf_write_data;
  logic                      rt2vcsr_write_valid;
  vcsr_t                     rt2vcsr_write_data;
  logic                      rt2vsat_write_valid;
  logic                      rt2vsat_write_data;

  rvv_retire_rob rvv_retire_rob_inst (
    .clk                (clk),
    .arst_n             (arst_n),
    .enq_valid          (enq_valid),
    .enq_uop            (enq_uop),
    .enq_ready          (enq_ready),
    .rob2rt_write_valid (rob2rt_write_valid),
    .rob2rt_write_data  (rob2rt_write_data),
    .rob2rt_write_ready (rob2rt_write_ready)
  );

  rvv_backend_retire rvv_backend_retire_inst (
    .rob2rt_write_valid  (rob2rt_write_valid),
    .rob2rt_write_data   (rob2rt_write_data),
    .rob2rt_write_ready  (rob2rt_write_ready),
    .rt2xrf_write_valid  (rt2xrf_write_valid),
    .rt2xrf_write_data   (rt2xrf_write_data),
    .rt2xrf_write_ready  (rt2xrf_write_ready),
    .rt2vrf_write_valid  (rt2vrf_write_valid),
    .rt2vrf_write_data   (rt2vrf_write_data),
    .rt2vcsr_write_valid (rt2vcsr_write_valid),
    .rt2vcsr_write_data  (rt2vcsr_write_data),
    .rt2vsat_write_valid (rt2vsat_write_valid),
    .rt2vsat_write_data  (rt2vsat_write_data)
  );

  rvv_vrf rvv_vrf_inst (
    .clk                (clk),
    .arst_n             (arst_n),
    .rt2vrf_write_valid (rt2vrf_write_valid),
    .rt2vrf_write_data  (rt2vrf_write_data),
    .rd_index           (rd_index),
    .rd_data            (rd_data)
  );

  rvv_vcsr rvv_vcsr_inst (
    .clk                 (clk),
    .arst_n              (arst_n),
    .rt2vcsr_write_valid (rt2vcsr_write_valid),
    .rt2vcsr_write_data  (rt2vcsr_write_data),
    .rt2vsat_write_valid (rt2vsat_write_valid),
    .rt2vsat_write_data  (rt2vsat_write_data),
    .vcsr_q              (vcsr_q),
    .vxsat_q             (vxsat_q)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_rvv_retire.sv ====
//////////////////////////////////////////////////
// testbench for the vector retire path
// enqueues random uop streams into the rob, keeps
// a queue model of the rob with a model vrf and
// csr state, checks every xrf port and the watched
// vrf register each cycle and reads the whole vrf
// back after each test
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_rvv_retire import rvv_retire_pkg::*; ();

  localparam int clk_period   = 8;
  localparam int reset_cycles = 16;
  localparam int num_tests    = 5;
  localparam int total_uops   = 4 * 8 + 32 + 7 + 8 + 6;
  localparam int stim_cycles  = reset_cycles + num_tests * (num_vreg + 2) + total_uops * 4;

  localparam int rdy_all    = 0;
  localparam int rdy_random = 1;
  localparam int rdy_stall  = 2;

  logic                           clk;
  logic                           arst_n;
  logic                           enq_valid;
  rob2rt_t                        enq_uop;
  logic                           enq_ready;
  logic    [num_rt_uop-1:0]       rt2xrf_write_valid;
  rt2xrf_t [num_rt_uop-1:0]       rt2xrf_write_data;
  logic    [num_rt_uop-1:0]       rt2xrf_write_ready;
  logic    [reg_idx_w-1:0]        rd_index;
  logic    [vlen-1:0]             rd_data;
  vcsr_t                          vcsr_q;
  logic                           vxsat_q;

  // reference state
  rob2rt_t         rob_q[$];
  logic [vlen-1:0] model_vrf [num_vreg];
  vcsr_t           model_vcsr;
  logic            model_vxsat;

  int ready_mode;
  int errors;
  int checks;
  int test_num;

  rvv_retire_top rvv_retire_top_inst (
    .clk                (clk),
    .arst_n             (arst_n),
    .enq_valid          (enq_valid),
    .enq_uop            (enq_uop),
    .enq_ready          (enq_ready),
    .rt2xrf_write_valid (rt2xrf_write_valid),
    .rt2xrf_write_data  (rt2xrf_write_data),
    .rt2xrf_write_ready (rt2xrf_write_ready),
    .rd_index           (rd_index),
    .rd_data            (rd_data),
    .vcsr_q             (vcsr_q),
    .vxsat_q            (vxsat_q)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  //////////////////////////////////////////////////
  // reference functions
  function automatic logic [vlen-1:0] merge_bytes(input logic [vlen-1:0] old,
                                                  input rob2rt_t u);
    logic [vlen-1:0] w;
    w = old;
    for (int b = 0; b < vlenb; b++) begin
      if (u.vd_type[b] == bt_body_active) begin
        w[b*8 +: 8] = u.w_data.vec[b*8 +: 8];
      end
    end
    return w;
  endfunction

  // applies one popped uop in age order
  function automatic void apply_uop(input rob2rt_t u);
    if (u.w_valid && !u.w_type) begin
      model_vrf[u.w_index] = merge_bytes(model_vrf[u.w_index], u);
    end
    if (u.trap_flag) begin
      model_vcsr = u.vector_csr;
    end
    model_vxsat = model_vxsat | u.vxsat;
  endfunction

  function automatic rt2xrf_t xrf_expect(input rob2rt_t u);
    rt2xrf_t x;
    x.rt_index = u.w_index;
    x.rt_data  = u.w_data.scl.data;  // low xlen bits only
    return x;
  endfunction

  function automatic rob2rt_t rand_uop(input logic xrf, input logic trap, input logic sat);
    rob2rt_t u;
    u = '0;
    u.w_valid = ($urandom_range(0, 7) != 0);
    u.w_type  = xrf;
    u.w_index = reg_idx_w'($urandom_range(0, 3));  // only four registers so writes overlap
    for (int b = 0; b < vlenb; b++) begin
      u.vd_type[b] = 2'($urandom_range(0, 3));
    end
    u.w_data.vec = {$urandom, $urandom};
    u.trap_flag  = trap;
    u.vector_csr = 24'($urandom);
    u.vxsat      = sat;
    return u;
  endfunction

  task automatic check_hex(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    assert (got === exp)
    else begin
      $display("** Error: %s = 0x%h, expected 0x%h at %0t", name, got, exp, $time);
      errors++;
    end
  endtask

  //////////////////////////////////////////////////
  // comparator runs mid-cycle where outputs are settled
  always @(negedge clk) begin : compare
    logic [num_rt_uop-1:0] exp_xv;
    logic                  stop;
    logic                  flush;
    logic                  enq_ok;
    int                    n_pop;
    rob2rt_t               u;
    if (arst_n) begin
      enq_ok = (rob_q.size() < rob_depth);
      check_hex("enq_ready", 64'(enq_ready), 64'(enq_ok));
      check_hex("vcsr_q", 64'(vcsr_q), 64'(model_vcsr));
      check_hex("vxsat_q", 64'(vxsat_q), 64'(model_vxsat));
      check_hex($sformatf("rd_data[v%0d]", rd_index), rd_data, model_vrf[rd_index]);
      exp_xv = '0;
      stop   = 1'b0;
      flush  = 1'b0;
      n_pop  = 0;
      for (int i = 0; i < num_rt_uop; i++) begin
        if (!stop && i < rob_q.size()) begin
          u = rob_q[i];
          exp_xv[i] = u.w_valid && u.w_type;
          if (exp_xv[i] && !rt2xrf_write_ready[i]) begin
            stop = 1'b1;  // held port stalls the younger ones
          end else begin
            n_pop++;
            if (u.trap_flag) begin
              flush = 1'b1;
              stop  = 1'b1;
            end
          end
        end else begin
          stop = 1'b1;
        end
      end
      check_hex("rt2xrf_write_valid", 64'(rt2xrf_write_valid), 64'(exp_xv));
      for (int i = 0; i < num_rt_uop; i++) begin
        if (exp_xv[i] && rt2xrf_write_ready[i]) begin
          check_hex($sformatf("rt2xrf_write_data[%0d]", i), 64'(rt2xrf_write_data[i]),
                    64'(xrf_expect(rob_q[i])));
        end
      end
      for (int k = 0; k < n_pop; k++) begin
        apply_uop(rob_q.pop_front());
      end
      if (flush) begin
        rob_q.delete();
      end
      if (enq_valid && enq_ok) begin
        rob_q.push_back(enq_uop);  // survives a flush on the same edge
      end
    end
  end

  // xrf ready driver samples the mode at the edge
  initial begin : xrf_ready_drive
    int mode;
    rt2xrf_write_ready = '1;
    forever begin
      @(posedge clk);
      mode = ready_mode;
      #1;
      case (mode)
        rdy_all:    rt2xrf_write_ready = '1;
        rdy_random: rt2xrf_write_ready = 4'($urandom);
        default:    rt2xrf_write_ready = '0;
      endcase
    end
  end

  initial begin : watchdog
    #(stim_cycles * 20 * clk_period);
    $display("watchdog expired, the run did not finish in time");
    $display("TB FAILED");
    $finish;
  end

  //////////////////////////////////////////////////
  // stimulus tasks return 1 ns after a rising edge
  task automatic enqueue(input rob2rt_t u);
    enq_valid = 1'b1;
    enq_uop   = u;
    rd_index  = u.w_index;  // watch the target register meanwhile
    @(negedge clk);
    while (!enq_ready) @(negedge clk);
    @(posedge clk);
    #1;
    enq_valid = 1'b0;
  endtask

  task automatic drain();
    while (rob_q.size() != 0) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic read_back_vrf();
    for (int r = 0; r < num_vreg; r++) begin
      rd_index = reg_idx_w'(r);
      @(negedge clk);
      check_hex($sformatf("rd_data[v%0d]", r), rd_data, model_vrf[r]);
      @(posedge clk);
      #1;
    end
  endtask

  task automatic report_test(input string name, input int err_start);
    test_num++;
    $display("test %0d %s %0d errors", test_num, name, errors - err_start);
  endtask

  // xrf uop at the head with no ready keeps the rob filling
  task automatic stall_head();
    rob2rt_t u;
    u = rand_uop(1'b1, 1'b0, 1'b0);
    u.w_valid = 1'b1;
    enqueue(u);
  endtask

  //////////////////////////////////////////////////
  // test sequence
  initial begin : main
    int      err_start;
    rob2rt_t trap_uop;
    void'($urandom(32'h8f3b));
    arst_n      = 1'b0;
    enq_valid   = 1'b0;
    enq_uop     = '0;
    rd_index    = '0;
    ready_mode  = rdy_all;
    model_vcsr  = '0;
    model_vxsat = 1'b0;
    for (int r = 0; r < num_vreg; r++) begin
      model_vrf[r] = '0;
    end
    repeat (reset_cycles) @(posedge clk);
    #1;
    arst_n = 1'b1;

    err_start = errors;
    @(negedge clk);
    check_hex("enq_ready", 64'(enq_ready), 64'd1);
    check_hex("rt2xrf_write_valid", 64'(rt2xrf_write_valid), 64'd0);
    check_hex("vcsr_q", 64'(vcsr_q), 64'd0);
    check_hex("vxsat_q", 64'(vxsat_q), 64'd0);
    @(posedge clk);
    #1;
    read_back_vrf();
    report_test("reset", err_start);

    // full windows of vector writes behind a stalled head
    err_start = errors;
    repeat (4) begin
      ready_mode = rdy_stall;
      stall_head();
      repeat (7) enqueue(rand_uop(1'b0, 1'b0, 1'b0));
      ready_mode = rdy_all;
      drain();
    end
    read_back_vrf();
    report_test("vrf_waw", err_start);

    err_start = errors;
    ready_mode = rdy_random;
    repeat (32) enqueue(rand_uop(1'($urandom_range(0, 1)), 1'b0, 1'b0));
    drain();
    read_back_vrf();
    report_test("xrf_order", err_start);

    // younger uops carry vxsat and must vanish
    err_start = errors;
    ready_mode = rdy_stall;
    stall_head();
    enqueue(rand_uop(1'b0, 1'b0, 1'b0));
    trap_uop = rand_uop(1'b0, 1'b1, 1'b0);
    enqueue(trap_uop);
    repeat (4) enqueue(rand_uop(1'($urandom_range(0, 1)), 1'b0, 1'b1));
    ready_mode = rdy_random;
    drain();
    check_hex("vcsr_q", 64'(vcsr_q), 64'(trap_uop.vector_csr));
    check_hex("vxsat_q", 64'(vxsat_q), 64'd0);
    repeat (8) enqueue(rand_uop(1'($urandom_range(0, 1)), 1'b0, 1'b0));
    drain();
    read_back_vrf();
    report_test("trap_flush", err_start);

    err_start = errors;
    ready_mode = rdy_all;
    enqueue(rand_uop(1'b0, 1'b0, 1'b1));
    repeat (5) enqueue(rand_uop(1'($urandom_range(0, 1)), 1'b0, 1'b0));
    drain();
    check_hex("vxsat_q", 64'(vxsat_q), 64'd1);
    read_back_vrf();
    report_test("vxsat_sticky", err_start);

    $display("tests %0d, checks %0d, errors %0d", test_num, checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
rtl/rvv_retire_pkg.sv
rtl/rvv_retire_rob.sv
rtl/rvv_backend_retire.sv
rtl/rvv_vrf.sv
rtl/rvv_vcsr.sv
rtl/rvv_retire_top.sv
testbench/tb_rvv_retire.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the retire testbench with verilator
# the simulation log decides pass or fail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --top-module tb_rvv_retire \
  -f flist.f -o tb_sim > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
grep -q "TB PASSED" sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
